/* verilog/muldiv_pkg.sv */
// Shared widths, vector types and enums for the bit-serial multiplier/divider and its testbench
`default_nettype none

package muldiv_pkg;

   // Datapath width, one operand or one result half
   localparam int ALU_WIDTH  = 8;

   // One iteration per operand bit
   localparam int STEP_COUNT = ALU_WIDTH;

   // Operand, result half, Q or M contents
   typedef logic [ALU_WIDTH-1:0] word_t;

   // Sum with carry, or partial remainder with its extra top bit
   typedef logic [ALU_WIDTH:0] wide_t;

   // Step counter, holds 0 up to STEP_COUNT
   typedef logic [$clog2(STEP_COUNT):0] count_t;

   // Operation select, latched at start
   typedef enum logic {
      OP_MUL = 1'b0,  // Unsigned shift-and-add multiply
      OP_DIV = 1'b1   // Unsigned restoring divide
   } op_t;

   // Controller states
   typedef enum logic [1:0] {
      ST_IDLE = 2'd0,  // Waiting for start
      ST_RUN  = 2'd1,  // Iterating, one bit per clock
      ST_DONE = 2'd2   // Result valid, done pulse
   } state_t;

endpackage

`default_nettype wire

/* verilog/muldiv_ctrl.sv */
// Sequencer for the multiplier/divider; accepts start, runs the bit steps and pulses done
`default_nettype none

module muldiv_ctrl
   import muldiv_pkg::*;
(
   input  logic clk,
   input  logic rst,
   input  logic start,  // Sampled only while idle
   input  op_t  op,
   output logic load,   // Datapath captures operands
   output logic step,   // Datapath does one iteration
   output op_t  op_q,   // Operation of the running job
   output logic busy,
   output logic done
);

   state_t state;
   count_t cnt;        // Steps taken so far
   logic   last;       // All steps taken, settle cycle

   assign last = (cnt == count_t'(STEP_COUNT));

   // Start is only seen in idle, so a start while busy is dropped
   assign load = (state == ST_IDLE) && start;
   assign step = (state == ST_RUN) && !last;  // Final RUN cycle has no step
   assign busy = (state == ST_RUN) || (state == ST_DONE);
   assign done = (state == ST_DONE);

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= ST_IDLE;
         cnt   <= '0;
         op_q  <= OP_MUL;
      end else begin
         case (state)
            ST_IDLE: begin
               if (start) begin
                  state <= ST_RUN;
                  cnt   <= '0;
                  op_q  <= op;  // Held for the whole job
               end
            end
            ST_RUN: begin
               if (last)
                  state <= ST_DONE;
               else
                  cnt <= cnt + count_t'(1);  // One per step edge
            end
            ST_DONE: state <= ST_IDLE;  // Single cycle of done
            default: state <= ST_IDLE;
         endcase
      end
   end

   // Loading and stepping never overlap
   a_load_step_excl: assert property (@(posedge clk) disable iff (rst)
      !(load && step));

   // A loaded job takes exactly STEP_COUNT steps, one quiet cycle, then done
   a_job_sequence: assert property (@(posedge clk) disable iff (rst)
      load |=> step [*STEP_COUNT] ##1 (busy && !step) ##1 done);

   // Done is a one-cycle pulse
   a_done_pulse: assert property (@(posedge clk) disable iff (rst)
      done |=> !done);

endmodule

`default_nettype wire

/* verilog/muldiv_alu.sv */
// Operand register with adder/trial subtractor; gives each step its new value and accept bit
`default_nettype none

module muldiv_alu
   import muldiv_pkg::*;
(
   input  logic  clk,
   input  logic  rst,
   input  logic  load,
   input  word_t operand,  // Multiplicand or divisor
   input  op_t   op,
   input  wide_t partial,  // Current Q view from the accumulator
   input  logic  m_lsb,    // Multiplier bit for this step
   output wide_t sum,      // Sum with carry or trial difference
   output logic  accept    // Step takes sum
);

   word_t operand_q;  // Latched like rDee
   wide_t operand_w;  // Zero-extended to partial width
   logic  no_borrow;

   always_ff @(posedge clk) begin
      if (rst)
         operand_q <= '0;
      else if (load)
         operand_q <= operand;  // Stable for the whole job
   end

   assign operand_w = {1'b0, operand_q};

   // Carry lands in the top bit for multiply
   // Partial top is zero there, so no overflow
   always_comb begin
      if (op == OP_MUL)
         sum = partial + operand_w;
      else
         sum = partial - operand_w;  // Wraps on borrow, then unused
   end

   // Restoring rule, subtract succeeds when partial is not below divisor
   assign no_borrow = (partial >= operand_w);

   // Multiplier bit selects the add, quotient bit is the borrow test
   assign accept = (op == OP_MUL) ? m_lsb : no_borrow;

endmodule

`default_nettype wire

/* verilog/muldiv_acc.sv */
// Upper-half Q register; holds product high byte or the partial remainder during iteration
`default_nettype none

module muldiv_acc
   import muldiv_pkg::*;
(
   input  logic  clk,
   input  logic  rst,
   input  logic  load,
   input  logic  step,
   input  op_t   op,
   input  logic  m_msb,      // Dividend bit moving up from M
   input  wide_t sum,
   input  logic  accept,
   output wide_t partial,    // Q as seen by the ALU
   output logic  shift_out,  // Low bit leaving Q on multiply
   output word_t q
);

   wide_t mul_next;  // Value before the right shift
   wide_t div_next;  // New remainder, top bit always clear

   // Multiply adds to Q, divide shifts Q left first
   assign partial = (op == OP_MUL) ? {1'b0, q} : {q, m_msb};

   // Keep Q when the multiplier bit is zero
   assign mul_next = accept ? sum : {1'b0, q};

   // Restore on borrow by taking the shifted partial back
   assign div_next = accept ? sum : partial;

   assign shift_out = mul_next[0];  // Enters M at the top

   always_ff @(posedge clk) begin
      if (rst) begin
         q <= '0;
      end else if (load) begin
         q <= '0;  // Fresh accumulator for each job
      end else if (step) begin
         if (op == OP_MUL)
            q <= mul_next[ALU_WIDTH:1];  // Carry comes in at the top
         else
            q <= div_next[ALU_WIDTH-1:0];
      end
   end

   // Remainder stays below the divisor, so nothing is lost off the top
   a_div_top_clear: assert property (@(posedge clk) disable iff (rst)
      (step && op == OP_DIV) |-> !div_next[ALU_WIDTH]);

endmodule

`default_nettype wire

/* verilog/muldiv_mreg.sv */
// Lower-half M shift register; multiplier shifts out right, quotient shifts in left
`default_nettype none

module muldiv_mreg
   import muldiv_pkg::*;
(
   input  logic  clk,
   input  logic  rst,
   input  logic  load,
   input  logic  step,
   input  op_t   op,
   input  word_t data,      // Multiplier or dividend
   input  logic  shift_in,  // Product bit from Q
   input  logic  accept,    // Quotient bit
   output word_t m,
   output logic  m_lsb,
   output logic  m_msb
);

   always_ff @(posedge clk) begin
      if (rst) begin
         m <= '0;
      end else if (load) begin
         m <= data;
      end else if (step) begin
         if (op == OP_MUL)
            m <= {shift_in, m[ALU_WIDTH-1:1]};  // Right, product low byte fills in
         else
            m <= {m[ALU_WIDTH-2:0], accept};    // Left, dividend leaves at top
      end
   end

   assign m_lsb = m[0];            // Next multiplier bit
   assign m_msb = m[ALU_WIDTH-1];  // Next dividend bit

endmodule

`default_nettype wire

/* verilog/muldiv_top.sv */
// Top level of the iterative multiplier/divider; start/busy/done interface around Q and M
`default_nettype none

module muldiv_top
   import muldiv_pkg::*;
(
   input  logic  clk,
   input  logic  rst,
   input  logic  start,
   input  op_t   op,
   input  word_t operand_a,  // Multiplier or dividend
   input  word_t operand_b,  // Multiplicand or divisor
   output logic  busy,
   output logic  done,
   output word_t result_hi,  // Product high byte or remainder
   output word_t result_lo   // Product low byte or quotient
);

   logic  load;
   logic  step;
   op_t   op_q;
   wide_t partial;
   wide_t sum;
   logic  accept;
   logic  shift_out;
   logic  m_lsb;
   logic  m_msb;

   muldiv_ctrl u_ctrl (
      .clk   (clk),
      .rst   (rst),
      .start (start),
      .op    (op),
      .load  (load),
      .step  (step),
      .op_q  (op_q),
      .busy  (busy),
      .done  (done)
   );

   muldiv_alu u_alu (
      .clk     (clk),
      .rst     (rst),
      .load    (load),
      .operand (operand_b),
      .op      (op_q),
      .partial (partial),
      .m_lsb   (m_lsb),
      .sum     (sum),
      .accept  (accept)
   );

   // Q register drives the high result
   muldiv_acc u_acc (
      .clk       (clk),
      .rst       (rst),
      .load      (load),
      .step      (step),
      .op        (op_q),
      .m_msb     (m_msb),
      .sum       (sum),
      .accept    (accept),
      .partial   (partial),
      .shift_out (shift_out),
      .q         (result_hi)
   );

   // M register drives the low result
   muldiv_mreg u_mreg (
      .clk      (clk),
      .rst      (rst),
      .load     (load),
      .step     (step),
      .op       (op_q),
      .data     (operand_a),
      .shift_in (shift_out),
      .accept   (accept),
      .m        (result_lo),
      .m_lsb    (m_lsb),
      .m_msb    (m_msb)
   );

endmodule

`default_nettype wire

/* tests/muldiv_tb.sv */
// Self-checking testbench for muldiv_top; replays the stim file vectors, then LFSR operand pairs
`default_nettype none

module muldiv_tb
   import muldiv_pkg::*;
();

   localparam int          MAX_VECTORS = 32;
   localparam int          FIELDS      = 5;   // op, a, b, hi, lo
   localparam int          N_RANDOM    = 16;  // Extra LFSR pairs
   localparam int          MARGIN      = 50;  // Slack cycles for the watchdog
   localparam logic [31:0] LFSR_SEED   = 32'h5033d6a8;
   localparam logic [31:0] LFSR_TAPS   = 32'h80200003;

   logic  clk;
   logic  rst;
   logic  start;
   op_t   op;
   word_t operand_a;
   word_t operand_b;
   logic  busy;
   logic  done;
   word_t result_hi;
   word_t result_lo;

   logic [7:0]  stim_mem [0:MAX_VECTORS*FIELDS-1];  // Flat array of five bytes per vector
   int          n_vectors;
   int          errors;
   int          timeout_cycles;
   logic        loaded;      // Watchdog waits for the vector count
   logic [31:0] lfsr_state;

   muldiv_top uut (
      .clk       (clk),
      .rst       (rst),
      .start     (start),
      .op        (op),
      .operand_a (operand_a),
      .operand_b (operand_b),
      .busy      (busy),
      .done      (done),
      .result_hi (result_hi),
      .result_lo (result_lo)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // Galois form with one shift per bit drawn
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      if (s[0])
         return (s >> 1) ^ LFSR_TAPS;
      else
         return s >> 1;
   endfunction

   task automatic draw_bits(input int n, output logic [7:0] val);
      val = '0;
      for (int k = 0; k < n; k++) begin
         lfsr_state = lfsr_next(lfsr_state);
         val = {val[6:0], lfsr_state[0]};  // MSB first
      end
   endtask

   // Reference results straight from the arithmetic rules
   task automatic expect_result(input logic op_bit, input word_t a, input word_t b,
                                output word_t exp_hi, output word_t exp_lo);
      logic [15:0] prod;
      prod = a * b;
      if (op_bit == 1'b0) begin
         {exp_hi, exp_lo} = prod;
      end else if (b == 8'h00) begin
         exp_hi = a;      // Divide by zero keeps the dividend
         exp_lo = 8'hFF;  // and gives all ones
      end else begin
         exp_hi = a % b;
         exp_lo = a / b;
      end
   endtask

   task automatic report_mismatch(input string name, input logic [15:0] expected,
                                  input logic [15:0] actual);
      $display("ERROR %s expected %h got %h at %0t", name, expected, actual, $time);
      errors++;
   endtask

   // One job from start to idle; poke sends a second start while busy
   task automatic run_job(input logic op_bit, input word_t a, input word_t b,
                          input word_t exp_hi, input word_t exp_lo, input logic poke);
      int edges;
      @(posedge clk);
      #1;
      start     = 1'b1;
      op        = op_t'(op_bit);
      operand_a = a;
      operand_b = b;
      @(posedge clk);  // Sampling edge
      #1;
      start = 1'b0;
      edges = 0;
      if (busy !== 1'b1) report_mismatch("busy", 16'h1, {15'h0, busy});
      while (done !== 1'b1 && edges <= STEP_COUNT + 2) begin
         if (poke && edges == 3) begin
            start     = 1'b1;  // Must be ignored
            op        = op_t'(~op_bit);
            operand_a = ~a;
            operand_b = ~b;
         end else begin
            start = 1'b0;
         end
         @(posedge clk);
         #1;
         edges++;
         if (busy !== 1'b1) report_mismatch("busy", 16'h1, {15'h0, busy});
      end
      start = 1'b0;
      if (done !== 1'b1) begin
         $display("ERROR done never rose within %0d edges of start at %0t", edges, $time);
         errors++;
      end else if (edges != STEP_COUNT + 1) begin
         $display("ERROR done rose %0d edges after start instead of %0d at %0t",
                  edges, STEP_COUNT + 1, $time);
         errors++;
      end
      if (result_hi !== exp_hi) report_mismatch("result_hi", {8'h0, exp_hi}, {8'h0, result_hi});
      if (result_lo !== exp_lo) report_mismatch("result_lo", {8'h0, exp_lo}, {8'h0, result_lo});
      @(posedge clk);
      #1;
      if (done !== 1'b0) report_mismatch("done", 16'h0, {15'h0, done});  // One cycle only
      if (busy !== 1'b0) report_mismatch("busy", 16'h0, {15'h0, busy});
      if (result_hi !== exp_hi) report_mismatch("result_hi", {8'h0, exp_hi}, {8'h0, result_hi});
      if (result_lo !== exp_lo) report_mismatch("result_lo", {8'h0, exp_lo}, {8'h0, result_lo});
   endtask

   initial begin
      logic  rop;
      word_t ra;
      word_t rb;
      word_t eh;
      word_t el;
      logic [7:0] rbits;
      start      = 1'b0;
      op         = OP_MUL;
      operand_a  = '0;
      operand_b  = '0;
      rst        = 1'b1;
      errors     = 0;
      loaded     = 1'b0;
      lfsr_state = LFSR_SEED;
      $readmemh("tests/muldiv_stim.hex", stim_mem);
      n_vectors = 0;
      while (n_vectors < MAX_VECTORS && !$isunknown(stim_mem[n_vectors*FIELDS]))
         n_vectors++;  // First unwritten op ends the list
      if (n_vectors == 0) begin
         $display("ERROR no vectors could be read from tests/muldiv_stim.hex");
         errors++;
      end
      timeout_cycles = (n_vectors + N_RANDOM) * (STEP_COUNT + 6) + 3 + MARGIN;
      loaded = 1'b1;
      repeat (3) @(posedge clk);
      #1;
      rst = 1'b0;
      if (busy !== 1'b0) report_mismatch("busy", 16'h0, {15'h0, busy});
      if (done !== 1'b0) report_mismatch("done", 16'h0, {15'h0, done});
      for (int i = 0; i < n_vectors; i++) begin
         run_job(stim_mem[i*FIELDS][0], stim_mem[i*FIELDS+1], stim_mem[i*FIELDS+2],
                 stim_mem[i*FIELDS+3], stim_mem[i*FIELDS+4], (i % 4) == 1);
      end
      for (int i = 0; i < N_RANDOM; i++) begin
         draw_bits(1, rbits);
         rop = rbits[0];
         draw_bits(8, ra);
         draw_bits(8, rb);
         expect_result(rop, ra, rb, eh, el);
         run_job(rop, ra, rb, eh, el, (i % 3) == 0);
      end
      $display("Jobs run %0d, errors %0d", n_vectors + N_RANDOM, errors);
      if (errors == 0)
         $display("Finished with no errors");
      else
         $display("Finished with errors");
      $finish;
   end

   // Watchdog sized from the vector count
   initial begin
      wait (loaded);
      repeat (timeout_cycles) @(posedge clk);
      $display("Timeout, the run did not complete within %0d cycles", timeout_cycles);
      $display("Jobs run incomplete, errors %0d", errors);
      $display("Finished with errors");
      $finish;
   end

endmodule

`default_nettype wire

/* tests/muldiv_stim.hex */
// Columns: op (00 mul, 01 div), a, b, expected result_hi, expected result_lo
// Multiply gives {hi,lo} = a*b; divide gives hi = remainder, lo = quotient
00 00 00 00 00
00 01 01 00 01
00 ff ff fe 01
00 aa 55 38 72
00 55 aa 38 72
00 ff 01 00 ff
00 0f 10 00 f0
00 80 02 01 00
00 12 34 03 a8
00 c8 7b 60 18
01 64 07 02 0e
01 03 09 03 00
01 2a 2a 00 01
01 c8 01 00 c8
01 ff 10 0f 0f
01 ff ff 00 01
01 00 05 00 00
01 5b 00 5b ff
01 00 00 00 ff
01 e7 0d 0a 11

/* all.f */
verilog/muldiv_pkg.sv
verilog/muldiv_ctrl.sv
verilog/muldiv_alu.sv
verilog/muldiv_acc.sv
verilog/muldiv_mreg.sv
verilog/muldiv_top.sv
tests/muldiv_tb.sv

/* Bender.yml */
package:
  name: muldiv

sources:
  - files:
      - verilog/muldiv_pkg.sv
      - verilog/muldiv_ctrl.sv
      - verilog/muldiv_alu.sv
      - verilog/muldiv_acc.sv
      - verilog/muldiv_mreg.sv
      - verilog/muldiv_top.sv
  - target: test
    files:
      - tests/muldiv_tb.sv
